// File: src/cin_pkg.sv
`default_nettype none

package cin_pkg;

    // lane geometry
    localparam int NUM_LANES        = 4;
    localparam int NIBBLES_PER_WORD = 8;

    // expected training word on every lane
    localparam logic [31:0] TRAIN_VALUE = 32'hA55A6996;

    // per-lane register offsets, lane n sits at n*0x100
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_STATUS   = 8'h04;
    localparam logic [7:0] REG_CAPTURE  = 8'h08;
    localparam logic [7:0] REG_ERRCNT   = 8'h0C;
    localparam logic [7:0] REG_INTERVAL = 8'h10;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // plain vector types
    typedef logic [3:0]  cin_nibble_t;
    typedef logic [31:0] cin_word_t;
    typedef logic [24:0] err_count_t;
    typedef logic [23:0] interval_t;
    typedef logic [1:0]  lane_idx_t;
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;
    // slice position inside a word
    typedef logic [2:0]  nib_cnt_t;

    // last slice position of a word
    localparam nib_cnt_t NIB_LAST = nib_cnt_t'(NIBBLES_PER_WORD - 1);

    // register block to lane
    typedef struct packed {
        logic      lane_rst;
        logic      lock_req;
        logic      bitslip;
        interval_t interval;
        logic      interval_load;
    } lane_ctrl_t;

    // lane to register block and top
    typedef struct packed {
        logic      locked;
        cin_word_t word;
        logic      word_valid;
    } lane_stat_t;

    // lane to error store
    typedef struct packed {
        logic       req;
        err_count_t count;
    } err_push_t;

    // master to slave
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        WRESP,
        RRESP
    } axil_state_e;

    typedef enum logic [1:0] {
        MANUAL,
        SEARCH,
        LOCKED
    } align_state_e;

endpackage

`default_nettype wire

// File: src/cin_axil_regs.sv
`default_nettype none

module cin_axil_regs import cin_pkg::*; (
    input  wire             cin_clk_i,
    input  wire             rst,
    input  wire axil_req_t  axil_req_i,
    output axil_rsp_t       axil_rsp_o,
    output lane_ctrl_t      lane_ctrl_o [NUM_LANES],
    input  wire lane_stat_t lane_stat_i [NUM_LANES],
    output lane_idx_t       err_rd_idx_o,
    input  wire err_count_t err_rd_count_i
);

    // bus state and registered response
    axil_state_e state_q;
    axil_rsp_t   rsp_q;

    // per-lane control, pulses live here too
    lane_ctrl_t  ctrl_q [NUM_LANES];

    // decoded addresses
    lane_idx_t   wr_lane;
    lane_idx_t   rd_lane;
    logic [7:0]  wr_off;
    logic [7:0]  rd_off;
    logic        wr_mapped;
    logic        rd_mapped;

    // handshake cycles, ready pulse seen with valid still high
    logic        wr_hs;
    logic        rd_hs;
    axil_data_t  rd_data;

    // offset must be one of the five registers and bits 11:10 clear
    function automatic logic addr_mapped(axil_addr_t addr);
        logic off_ok;
        case (addr[7:0])
            REG_CTRL, REG_STATUS, REG_CAPTURE, REG_ERRCNT, REG_INTERVAL: off_ok = 1'b1;
            default: off_ok = 1'b0;
        endcase
        return off_ok && (addr[11:10] == 2'b00);
    endfunction

    assign wr_lane   = axil_req_i.awaddr[9:8];
    assign rd_lane   = axil_req_i.araddr[9:8];
    assign wr_off    = axil_req_i.awaddr[7:0];
    assign rd_off    = axil_req_i.araddr[7:0];
    assign wr_mapped = addr_mapped(axil_req_i.awaddr);
    assign rd_mapped = addr_mapped(axil_req_i.araddr);

    assign wr_hs = rsp_q.awready && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_hs = rsp_q.arready && axil_req_i.arvalid;

    // store count lookup follows the read address directly
    assign err_rd_idx_o = rd_lane;

    // read data mux, unmapped returns zero
    always_comb begin
        rd_data = '0;
        if (rd_mapped) begin
            case (rd_off)
                REG_CTRL:     rd_data = {30'b0, ctrl_q[rd_lane].lane_rst,
                                         ctrl_q[rd_lane].lock_req};
                REG_STATUS:   rd_data = {31'b0, lane_stat_i[rd_lane].locked};
                REG_CAPTURE:  rd_data = lane_stat_i[rd_lane].word;
                REG_ERRCNT:   rd_data = axil_data_t'(err_rd_count_i);
                REG_INTERVAL: rd_data = axil_data_t'(ctrl_q[rd_lane].interval);
                default:      rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            state_q <= IDLE;
            rsp_q   <= '0;
            for (int n = 0; n < NUM_LANES; n++) begin
                ctrl_q[n] <= '0;
            end
        end else begin
            // bitslip and interval_load are single-cycle strobes
            for (int n = 0; n < NUM_LANES; n++) begin
                ctrl_q[n].bitslip       <= 1'b0;
                ctrl_q[n].interval_load <= 1'b0;
            end
            // ready pulses last one cycle
            rsp_q.awready <= 1'b0;
            rsp_q.wready  <= 1'b0;
            rsp_q.arready <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (wr_hs) begin
                        state_q     <= WRESP;
                        rsp_q.bvalid <= 1'b1;
                        rsp_q.bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
                        if (wr_mapped) begin
                            case (wr_off)
                                REG_CTRL: begin
                                    if (axil_req_i.wstrb[0]) begin
                                        ctrl_q[wr_lane].lock_req <= axil_req_i.wdata[0];
                                        ctrl_q[wr_lane].lane_rst <= axil_req_i.wdata[1];
                                        ctrl_q[wr_lane].bitslip  <= axil_req_i.wdata[2];
                                    end
                                end
                                REG_INTERVAL: begin
                                    if (axil_req_i.wstrb[0])
                                        ctrl_q[wr_lane].interval[7:0] <= axil_req_i.wdata[7:0];
                                    if (axil_req_i.wstrb[1])
                                        ctrl_q[wr_lane].interval[15:8] <= axil_req_i.wdata[15:8];
                                    if (axil_req_i.wstrb[2])
                                        ctrl_q[wr_lane].interval[23:16] <= axil_req_i.wdata[23:16];
                                    // restart the lane's error interval
                                    ctrl_q[wr_lane].interval_load <= 1'b1;
                                end
                                // status, capture and errcnt ignore writes
                                default: ;
                            endcase
                        end
                    end else if (rd_hs) begin
                        state_q     <= RRESP;
                        rsp_q.rvalid <= 1'b1;
                        rsp_q.rdata  <= rd_data;
                        rsp_q.rresp  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
                    end else if (!rsp_q.awready && !rsp_q.arready) begin
                        // write wins when both arrive together
                        if (axil_req_i.awvalid && axil_req_i.wvalid) begin
                            rsp_q.awready <= 1'b1;
                            rsp_q.wready  <= 1'b1;
                        end else if (axil_req_i.arvalid) begin
                            rsp_q.arready <= 1'b1;
                        end
                    end
                end
                WRESP: begin
                    // hold response until master takes it
                    if (axil_req_i.bready) begin
                        rsp_q.bvalid <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                RRESP: begin
                    if (axil_req_i.rready) begin
                        rsp_q.rvalid <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign axil_rsp_o  = rsp_q;
    assign lane_ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: src/cin_lane_align.sv
`default_nettype none

module cin_lane_align import cin_pkg::*; (
    input  wire              cin_clk_i,
    input  wire              rst,
    input  wire cin_nibble_t nibble_i,
    input  wire lane_ctrl_t  ctrl_i,
    output lane_stat_t       stat_o,
    output err_push_t        push_o,
    input  wire              grant_i
);

    // lane reset covers global and soft reset
    logic         lrst;

    // slice shifter and the word it would form now
    cin_word_t    shift_q;
    cin_word_t    word_next;

    // word boundary counter
    nib_cnt_t     nib_cnt_q;
    // slip requested by the lock search
    logic         slip_q;
    logic         hold;
    logic         emit;
    logic         match;

    align_state_e state_q;

    // last emitted word
    cin_word_t    word_q;
    logic         valid_q;

    // bit error interval
    cin_word_t    err_bits;
    interval_t    wcnt_q;
    err_count_t   ecnt_q;
    err_count_t   ecnt_sum;
    logic         push_req_q;
    err_count_t   push_cnt_q;

    // number of set bits in a word
    function automatic logic [5:0] popcount32(cin_word_t v);
        logic [5:0] n;
        n = '0;
        for (int b = 0; b < $bits(cin_word_t); b++) begin
            n = n + 6'(v[b]);
        end
        return n;
    endfunction

    assign lrst = rst || ctrl_i.lane_rst;

    // first slice ends up in bits 31:28
    assign word_next = {shift_q[27:0], nibble_i};

    // a held count pushes the boundary one slice later
    assign hold  = ctrl_i.bitslip || slip_q;
    assign emit  = (nib_cnt_q == NIB_LAST) && !hold;
    assign match = (word_next == TRAIN_VALUE);

    assign err_bits = word_next ^ TRAIN_VALUE;
    assign ecnt_sum = ecnt_q + err_count_t'(popcount32(err_bits));

    always_ff @(posedge cin_clk_i) begin
        shift_q <= word_next;
    end

    // capture word at each boundary
    always_ff @(posedge cin_clk_i) begin
        if (emit) begin
            word_q <= word_next;
        end
    end

    // boundary counter and lock search
    always_ff @(posedge cin_clk_i) begin
        if (lrst) begin
            nib_cnt_q <= '0;
            slip_q    <= 1'b0;
            valid_q   <= 1'b0;
            state_q   <= MANUAL;
        end else begin
            if (!hold) begin
                nib_cnt_q <= (nib_cnt_q == NIB_LAST) ? '0 : nib_cnt_q + 1'b1;
            end
            slip_q  <= 1'b0;
            valid_q <= emit;
            case (state_q)
                MANUAL: begin
                    if (ctrl_i.lock_req) state_q <= SEARCH;
                end
                SEARCH: begin
                    if (!ctrl_i.lock_req) begin
                        state_q <= MANUAL;
                    end else if (emit) begin
                        // mismatch slips one slice and tries again
                        if (match) state_q <= LOCKED;
                        else       slip_q  <= 1'b1;
                    end
                end
                LOCKED: begin
                    if (!ctrl_i.lock_req) state_q <= MANUAL;
                end
                default: state_q <= MANUAL;
            endcase
        end
    end

    // error accumulation over the loaded interval
    always_ff @(posedge cin_clk_i) begin
        if (lrst) begin
            wcnt_q     <= '0;
            ecnt_q     <= '0;
            push_req_q <= 1'b0;
        end else begin
            if (grant_i) push_req_q <= 1'b0;
            if (ctrl_i.interval_load) begin
                wcnt_q <= '0;
                ecnt_q <= '0;
            end else if (state_q == LOCKED && emit && ctrl_i.interval != '0) begin
                if (wcnt_q == ctrl_i.interval - 1'b1) begin
                    // last word of interval, hand total to the store
                    push_req_q <= 1'b1;
                    push_cnt_q <= ecnt_sum;
                    wcnt_q     <= '0;
                    ecnt_q     <= '0;
                end else begin
                    wcnt_q <= wcnt_q + 1'b1;
                    ecnt_q <= ecnt_sum;
                end
            end
        end
    end

    // locked rises with the valid of the matching word
    assign stat_o = '{locked: (state_q == LOCKED), word: word_q, word_valid: valid_q};
    assign push_o = '{req: push_req_q, count: push_cnt_q};

endmodule

`default_nettype wire

// File: src/cin_err_store.sv
`default_nettype none

module cin_err_store import cin_pkg::*; (
    input  wire                  cin_clk_i,
    input  wire                  rst,
    input  wire err_push_t       push_i [NUM_LANES],
    output logic [NUM_LANES-1:0] grant_o,
    input  wire lane_idx_t       rd_idx_i,
    output err_count_t           rd_count_o
);

    // last lane granted, search starts after it
    lane_idx_t  last_q;
    lane_idx_t  win_idx;
    logic       win_valid;

    // one count per lane
    err_count_t mem_q [NUM_LANES];

    // round-robin pick over pending pushes
    always_comb begin
        lane_idx_t idx;
        win_idx   = last_q;
        win_valid = 1'b0;
        for (int k = 1; k <= NUM_LANES; k++) begin
            idx = lane_idx_t'(last_q + k);
            if (!win_valid && push_i[idx].req) begin
                win_idx   = idx;
                win_valid = 1'b1;
            end
        end
    end

    // one-hot grant back to lanes
    always_comb begin
        grant_o = '0;
        if (win_valid) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // write on the grant cycle
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            last_q <= '0;
            for (int n = 0; n < NUM_LANES; n++) begin
                mem_q[n] <= '0;
            end
        end else if (win_valid) begin
            mem_q[win_idx] <= push_i[win_idx].count;
            last_q         <= win_idx;
        end
    end

    // combinational read, registered by the bus slave
    assign rd_count_o = mem_q[rd_idx_i];

endmodule

`default_nettype wire

// File: src/turfio_cin_top.sv
`default_nettype none

module turfio_cin_top import cin_pkg::*; (
    input  wire                  cin_clk_i,
    input  wire                  rst,
    input  wire axil_req_t       axil_req_i,
    output axil_rsp_t            axil_rsp_o,
    input  wire cin_nibble_t     lane_data_i [NUM_LANES],
    output cin_word_t            cin_response_o [NUM_LANES],
    output logic [NUM_LANES-1:0] cin_valid_o
);

    // control, status and push per lane
    lane_ctrl_t           lane_ctrl [NUM_LANES];
    lane_stat_t           lane_stat [NUM_LANES];
    err_push_t            lane_push [NUM_LANES];
    logic [NUM_LANES-1:0] lane_grant;

    // store read port
    lane_idx_t            err_rd_idx;
    err_count_t           err_rd_count;

    cin_axil_regs u_regs (
        .cin_clk_i      (cin_clk_i),
        .rst            (rst),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .lane_ctrl_o    (lane_ctrl),
        .lane_stat_i    (lane_stat),
        .err_rd_idx_o   (err_rd_idx),
        .err_rd_count_i (err_rd_count)
    );

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        cin_lane_align u_lane (
            .cin_clk_i (cin_clk_i),
            .rst       (rst),
            .nibble_i  (lane_data_i[n]),
            .ctrl_i    (lane_ctrl[n]),
            .stat_o    (lane_stat[n]),
            .push_o    (lane_push[n]),
            .grant_i   (lane_grant[n])
        );

        // expose each lane's words
        assign cin_response_o[n] = lane_stat[n].word;
        assign cin_valid_o[n]    = lane_stat[n].word_valid;
    end

    cin_err_store u_store (
        .cin_clk_i  (cin_clk_i),
        .rst        (rst),
        .push_i     (lane_push),
        .grant_o    (lane_grant),
        .rd_idx_i   (err_rd_idx),
        .rd_count_o (err_rd_count)
    );

endmodule

`default_nettype wire

// File: tb/tb_cin_axil_tasks.svh
`ifndef TB_CIN_AXIL_TASKS_SVH
`define TB_CIN_AXIL_TASKS_SVH

// bus handshakes give up after this many cycles
localparam int BUS_WAIT_MAX = 50;

// value check, one line per mismatch
task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp) else begin
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        errors++;
    end
endtask

// condition check with a plain description
task automatic check_true(input string name, input logic cond, input string what);
    assert (cond) else begin
        $display("%s: %s", name, what);
        errors++;
    end
endtask

// single write, waits for awready then bvalid
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          input logic [3:0] strb, output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!axil_rsp.awready && waited < BUS_WAIT_MAX);
    // address and data are accepted in the same cycle
    check_true("axil_write", axil_rsp.wready, "wready did not rise with awready");
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!axil_rsp.bvalid && waited < BUS_WAIT_MAX);
    check_true("axil_write", waited < BUS_WAIT_MAX, "write response never arrived");
    resp = axil_rsp.bresp;
endtask

// single read, rready is held high so rvalid clears by itself
task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                         output logic [1:0] resp);
    int waited;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!axil_rsp.arready && waited < BUS_WAIT_MAX);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!axil_rsp.rvalid && waited < BUS_WAIT_MAX);
    check_true("axil_read", waited < BUS_WAIT_MAX, "read data never arrived");
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
endtask

// one summary line per test
task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: %0d check(s) wrong", name, errors - errs_before);
    end
endtask

`endif

// File: tb/tb_turfio_cin.sv
`default_nettype none

module tb_turfio_cin import cin_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // rough cycle budget of all tests, plus margin
    localparam int TEST_CYCLES = 300 + 200 + 500 + 100 + 400 + 400;
    localparam int CLK_NS      = 100;
    // eight words with a slip between each, plus status read latency
    localparam int LOCK_CYCLES = 8 * (NIBBLES_PER_WORD + 1) + 16;

    logic                 clk;
    logic                 rst;
    axil_req_t            axil_req;
    axil_rsp_t            axil_rsp;
    cin_nibble_t          lane_data [NUM_LANES];
    cin_word_t            cin_response [NUM_LANES];
    logic [NUM_LANES-1:0] cin_valid;

    // lane pattern state
    logic [2:0]  slice_idx [NUM_LANES];
    cin_word_t   cur_word [NUM_LANES];
    cin_word_t   mask [NUM_LANES];

    int errors;
    int tests_run;
    int tests_failed;

    `include "tb_cin_axil_tasks.svh"

    turfio_cin_top dut_i (
        .cin_clk_i      (clk),
        .rst            (rst),
        .axil_req_i     (axil_req),
        .axil_rsp_o     (axil_rsp),
        .lane_data_i    (lane_data),
        .cin_response_o (cin_response),
        .cin_valid_o    (cin_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // each lane repeats the training word, mask latched at the word start
    always @(posedge clk) begin : drive_lanes
        cin_word_t w;
        for (int n = 0; n < NUM_LANES; n++) begin
            w = (slice_idx[n] == 0) ? (TRAIN_VALUE ^ mask[n]) : cur_word[n];
            cur_word[n]  <= w;
            lane_data[n] <= w[31 - 4 * slice_idx[n] -: 4];
            slice_idx[n] <= slice_idx[n] + 3'd1;
        end
    end

    // random set of k distinct bits
    function automatic cin_word_t make_mask(input int k);
        cin_word_t m;
        m = '0;
        while ($countones(m) < k) begin
            m[$urandom_range(31)] = 1'b1;
        end
        return m;
    endfunction

    function automatic axil_addr_t reg_addr(input int lane, input logic [7:0] off);
        return axil_addr_t'(lane * 12'h100) | axil_addr_t'(off);
    endfunction

    // waits at falling edges for one valid on a lane
    task automatic wait_valid(input int lane, output cin_word_t w, output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!cin_valid[lane] && gap < 40);
        check_true("wait_valid", cin_valid[lane], "lane stopped emitting words");
        w = cin_response[lane];
    endtask

    // sits out a number of cycles
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    initial begin
        #(CLK_NS * TEST_CYCLES);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin : run_tests
        axil_data_t d;
        logic [1:0] resp;
        cin_word_t  w;
        int         gap;
        int         e0;
        int         t0;
        int         k;
        logic [2:0] phase;

        void'($urandom(99));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        axil_req     = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        // one random phase on every lane, so locked lanes push on the same cycle
        phase = 3'($urandom_range(7));
        for (int n = 0; n < NUM_LANES; n++) begin
            slice_idx[n] = phase;
            cur_word[n]  = TRAIN_VALUE;
            mask[n]      = '0;
            lane_data[n] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(2);

        // register readback, strobes and unmapped addresses
        e0 = errors;
        axil_write(reg_addr(1, REG_INTERVAL), 32'h0012_3456, 4'hF, resp);
        axil_read(reg_addr(1, REG_INTERVAL), d, resp);
        check_value("readback interval", 32'h0012_3456, d);
        axil_write(reg_addr(1, REG_INTERVAL), 32'hAABB_CCDD, 4'b0010, resp);
        axil_read(reg_addr(1, REG_INTERVAL), d, resp);
        check_value("readback interval strobe", 32'h0012_CC56, d);
        axil_write(reg_addr(2, REG_CTRL), 32'h7, 4'hF, resp);
        axil_read(reg_addr(2, REG_CTRL), d, resp);
        check_value("readback ctrl", 32'h3, d);
        axil_write(reg_addr(2, REG_CTRL), 32'h0, 4'hF, resp);
        axil_write(12'h014, 32'h1, 4'hF, resp);
        check_value("unmapped write resp", 32'(RESP_SLVERR), 32'(resp));
        axil_read(12'h400, d, resp);
        check_value("unmapped read resp", 32'(RESP_SLVERR), 32'(resp));
        check_value("unmapped read data", 32'h0, d);
        report_test("register readback", e0);

        // manual slip on lane 3, lock_req still clear
        e0 = errors;
        wait_valid(3, w, gap);
        axil_write(reg_addr(3, REG_CTRL), 32'h4, 4'hF, resp);
        wait_valid(3, d, gap);
        wait_valid(3, d, gap);
        check_value("bitslip word", {w[27:0], w[31:28]}, d);
        wait_valid(3, d, gap);
        check_value("bitslip next word", {w[27:0], w[31:28]}, d);
        report_test("manual bitslip", e0);

        // lock every lane from its random phase
        e0 = errors;
        for (int n = 0; n < NUM_LANES; n++) begin
            axil_write(reg_addr(n, REG_CTRL), 32'h1, 4'hF, resp);
            t0 = int'($time / CLK_NS);
            d  = '0;
            while (!d[0] && int'($time / CLK_NS) - t0 < LOCK_CYCLES) begin
                axil_read(reg_addr(n, REG_STATUS), d, resp);
            end
            check_true("lock", d[0], "lane did not lock within 8 words");
            for (int j = 0; j < 4; j++) begin
                wait_valid(n, w, gap);
                check_value("lock word", TRAIN_VALUE, w);
            end
        end
        report_test("lock", e0);

        // locked lanes emit every 8 cycles
        e0 = errors;
        wait_valid(0, w, gap);
        for (int j = 0; j < 5; j++) begin
            wait_valid(0, w, gap);
            check_value("word cadence", 32'(NIBBLES_PER_WORD), 32'(gap));
        end
        report_test("word cadence", e0);

        // clean interval first, then k flipped bits per word
        e0 = errors;
        axil_write(reg_addr(0, REG_INTERVAL), 32'd3, 4'hF, resp);
        idle_cycles(6 * NIBBLES_PER_WORD);
        axil_read(reg_addr(0, REG_ERRCNT), d, resp);
        check_value("clean errcnt", 32'h0, d);
        // no pushes while the mask changes
        axil_write(reg_addr(0, REG_INTERVAL), 32'd0, 4'hF, resp);
        mask[0] = make_mask(3);
        idle_cycles(2 * NIBBLES_PER_WORD);
        axil_write(reg_addr(0, REG_INTERVAL), 32'd4, 4'hF, resp);
        t0 = 0;
        d  = '0;
        while (d == 0 && t0 < 8 * NIBBLES_PER_WORD) begin
            axil_read(reg_addr(0, REG_ERRCNT), d, resp);
            t0 += 4;
        end
        check_value("errcnt k*N", 32'd12, d);
        report_test("bit errors", e0);

        // all lanes push into the shared store
        e0 = errors;
        for (int n = 0; n < NUM_LANES; n++) begin
            mask[n] = make_mask(n + 1);
        end
        idle_cycles(2 * NIBBLES_PER_WORD);
        for (int n = 0; n < NUM_LANES; n++) begin
            axil_write(reg_addr(n, REG_INTERVAL), 32'd5, 4'hF, resp);
        end
        idle_cycles(8 * NIBBLES_PER_WORD);
        for (int n = 0; n < NUM_LANES; n++) begin
            k = $countones(mask[n]);
            axil_read(reg_addr(n, REG_ERRCNT), d, resp);
            check_value("shared store errcnt", 32'(k * 5), d);
        end
        report_test("shared store", e0);

        $display("%0d tests run, %0d failed, %0d checks wrong",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
src/cin_pkg.sv
src/cin_axil_regs.sv
src/cin_lane_align.sv
src/cin_err_store.sv
src/turfio_cin_top.sv
tb/tb_turfio_cin.sv

// File: Makefile
# Verilator flow for the command-in receive side

VERILATOR ?= verilator
TOP       ?= tb_turfio_cin
RTL_TOP   ?= turfio_cin_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) tb/tb_cin_axil_tasks.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
